//--- verilog/ste_bus_pkg.sv
// CPU bus types and the decoded joystick register strobes, imported by the joypad port block
`default_nettype none

package ste_bus_pkg;

	// 68000 data bus as seen by the joystick registers
	typedef logic [15:0] cpu_word_t;

	// byte lane, used for the select latch and the select pins
	typedef logic [7:0] cpu_byte_t;

	// decoded register strobes coming from the address decoder
	typedef struct packed {
		// write pulse to the select latch
		logic joywl;
		// select pin output enable
		logic joywe_n;
		// read of the low data byte
		logic joyrl_n;
		// read of the high data byte
		logic joyrh_n;
		// read of the fire buttons
		logic button_n;
	} joy_strobes_t;

	// bus value when nothing drives it, the pull-ups win
	localparam cpu_word_t IDLE_WORD = 16'hffff;

endpackage

`default_nettype wire

//--- verilog/joypad_pkg.sv
// joypad matrix types, the per-port result and the port count for the STe joypad ports
`default_nettype none

package joypad_pkg;

	// number of extended joypad ports, fixed by the read word layout
	localparam int N_JOY_PORTS = 2;

	// key matrix geometry
	localparam int N_JOY_ROWS = 4;
	localparam int ROW_BITS   = 8;

	typedef logic [3:0] nibble_t;

	// four rows of 8 columns, row r at bits 8r+7..8r
	typedef logic [N_JOY_ROWS*ROW_BITS-1:0] key_matrix_t;

	// one bit per fire button
	typedef logic [1:0] fire_t;

	// state of one joypad, a set bit means pressed
	typedef struct packed {
		key_matrix_t keys;
		fire_t       fire;
	} joypad_state_t;

	// what a port returns to the read path, all active low
	typedef struct packed {
		nibble_t lo_n;
		nibble_t hi_n;
		fire_t   buttons_n;
	} port_result_t;

	// read mux bus state
	typedef enum logic {
		IDLE  = 1'b0,
		DRIVE = 1'b1
	} state_t;

endpackage

`default_nettype wire

//--- verilog/joy_out_latch.sv
// CPU-written select latch that the top level instantiates to drive the row selects of both ports
`timescale 1ns/100ps
`default_nettype none

module joy_out_latch
	import ste_bus_pkg::*;
(
	input  wire               clk_32,
	input  wire               xsint,
	input  wire joy_strobes_t strobes_i,
	input  wire cpu_byte_t    cpu_data_i,
	output cpu_byte_t         select_o
);

	cpu_byte_t select_q;

	// byte written by the CPU where all ones selects no row
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			select_q <= '1;
		end else if (strobes_i.joywl) begin
			select_q <= cpu_data_i;
		end
	end

	// pins float high while the output enable is off
	assign select_o = strobes_i.joywe_n ? cpu_byte_t'('1) : select_q;

	// write data must be clean when it is captured
	a_wr_data_known: assert property (
		@(posedge clk_32) disable iff (!xsint)
		strobes_i.joywl |-> !$isunknown(cpu_data_i)
	);

endmodule

`default_nettype wire

//--- verilog/joypad_port.sv
// one STe joypad port, scans the key matrix and fire buttons through the active-low row selects
`timescale 1ns/100ps
`default_nettype none

module joypad_port
	import joypad_pkg::*;
(
	input  wire nibble_t       select_i,
	input  wire                ste_mode_i,
	input  wire joypad_state_t joy_i,
	output port_result_t       result_o
);

	key_matrix_t keys;
	fire_t       fire;
	nibble_t     row_sel;
	nibble_t     lo_hit;
	nibble_t     hi_hit;
	fire_t       btn_hit;

	// with the port not in STe mode the pad looks released
	assign keys = ste_mode_i ? joy_i.keys : '0;
	assign fire = ste_mode_i ? joy_i.fire : '0;

	// a low select pin enables its row
	assign row_sel = ~select_i;

	// wired-AND of all selected rows onto the column lines
	always_comb begin
		lo_hit = '0;
		hi_hit = '0;
		for (int r = 0; r < N_JOY_ROWS; r++) begin
			if (row_sel[r]) begin
				lo_hit = lo_hit | keys[ROW_BITS*r +: 4];
				hi_hit = hi_hit | keys[ROW_BITS*r+4 +: 4];
			end
		end
	end

	// fire j only shows while row j is selected
	assign btn_hit = fire & row_sel[1:0];

	assign result_o = '{
		lo_n:      ~lo_hit,
		hi_n:      ~hi_hit,
		buttons_n: ~btn_hit
	};

endmodule

`default_nettype wire

//--- verilog/joy_read_mux.sv
// read-back path that the top level instantiates to build the registered CPU read word
`timescale 1ns/100ps
`default_nettype none

module joy_read_mux
	import ste_bus_pkg::*;
	import joypad_pkg::*;
(
	input  wire               clk_32,
	input  wire               xsint,
	input  wire joy_strobes_t strobes_i,
	input  wire port_result_t ports_i [N_JOY_PORTS],
	output cpu_word_t         rd_data_o
);

	cpu_word_t word_d;
	logic      rd_any;
	state_t    state_q;
	state_t    state_d;

	// any of the three read strobes
	assign rd_any = ~(strobes_i.joyrl_n & strobes_i.joyrh_n & strobes_i.button_n);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (rd_any) begin
					state_d = DRIVE;
				end
			end
			DRIVE: begin
				if (!rd_any) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	// sources are ANDed onto the bus starting from the pull-up value
	always_comb begin
		word_d = IDLE_WORD;
		for (int k = 0; k < N_JOY_PORTS; k++) begin
			// one low byte nibble per port
			if (!strobes_i.joyrl_n) begin
				word_d[4*k +: 4] = word_d[4*k +: 4] & ports_i[k].lo_n;
			end
			// high byte
			if (!strobes_i.joyrh_n) begin
				word_d[8+4*k +: 4] = word_d[8+4*k +: 4] & ports_i[k].hi_n;
			end
			// fire buttons share the low nibble of the word
			if (!strobes_i.button_n) begin
				word_d[2*k +: 2] = word_d[2*k +: 2] & ports_i[k].buttons_n;
			end
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			state_q   <= IDLE;
			rd_data_o <= IDLE_WORD;
		end else begin
			state_q   <= state_d;
			rd_data_o <= word_d;
		end
	end

	// an idle bus always reads as pull-ups
	a_idle_word: assert property (
		@(posedge clk_32) disable iff (!xsint)
		(state_q == IDLE) |-> (rd_data_o == IDLE_WORD)
	);

endmodule

`default_nettype wire

//--- verilog/ste_joy_top.sv
// top level of the STe extended joystick ports, select latch, two joypad ports and the read mux
`timescale 1ns/100ps
`default_nettype none

module ste_joy_top
	import ste_bus_pkg::*;
	import joypad_pkg::*;
(
	input  wire                clk_32,
	input  wire                xsint,
	input  wire joy_strobes_t  strobes_i,
	input  wire cpu_byte_t     cpu_data_i,
	input  wire                ste_mode_i,
	input  wire joypad_state_t joy_i [N_JOY_PORTS],
	output cpu_word_t          rd_data_o
);

	// select pins, nibble k drives port k
	cpu_byte_t    select;

	// per-port column and button lines
	port_result_t port_res [N_JOY_PORTS];

	joy_out_latch u_latch (
		.clk_32     ( clk_32     ),
		.xsint      ( xsint      ),
		.strobes_i  ( strobes_i  ),
		.cpu_data_i ( cpu_data_i ),
		.select_o   ( select     )
	);

	// port k reads joystick k
	for (genvar k = 0; k < N_JOY_PORTS; k++) begin : g_port
		joypad_port u_port (
			.select_i   ( select[4*k +: 4] ),
			.ste_mode_i ( ste_mode_i       ),
			.joy_i      ( joy_i[k]         ),
			.result_o   ( port_res[k]      )
		);
	end

	joy_read_mux u_rmux (
		.clk_32    ( clk_32    ),
		.xsint     ( xsint     ),
		.strobes_i ( strobes_i ),
		.ports_i   ( port_res  ),
		.rd_data_o ( rd_data_o )
	);

endmodule

`default_nettype wire

//--- tests/tb_ste_joy.sv
// directed testbench for the STe joypad port block that run_sim.sh builds through list.f
`timescale 1ns/100ps
`default_nettype none

module tb_ste_joy
	import ste_bus_pkg::*;
	import joypad_pkg::*;
();

	localparam int MAX_CYCLES = 2000;

	logic          clk_32 = 1'b0;
	logic          xsint;
	joy_strobes_t  strobes_i;
	cpu_byte_t     cpu_data_i;
	logic          ste_mode_i;
	joypad_state_t joy_i [N_JOY_PORTS];
	cpu_word_t     rd_data_o;

	// copies of the driven values for the model
	joypad_state_t pad_val [N_JOY_PORTS];
	logic          ste_val;
	cpu_byte_t     last_select;
	logic [31:0]   rng_state = 32'd3780;
	int            cycle_count = 0;
	int            fail_count = 0;

	ste_joy_top dut0 (
		.clk_32     ( clk_32     ),
		.xsint      ( xsint      ),
		.strobes_i  ( strobes_i  ),
		.cpu_data_i ( cpu_data_i ),
		.ste_mode_i ( ste_mode_i ),
		.joy_i      ( joy_i      ),
		.rd_data_o  ( rd_data_o  )
	);

	always #20 clk_32 = ~clk_32;

	always @(posedge clk_32) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: tests still running after %0d clock cycles", cycle_count);
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// expected bus word worked out bit by bit from the port and read rules
	function automatic cpu_word_t model_read(input cpu_byte_t sel, input joy_strobes_t stb,
		input logic ste, input joypad_state_t pad0, input joypad_state_t pad1);
		cpu_word_t     word;
		cpu_byte_t     pins;
		joypad_state_t pad;
		logic [3:0]    lo_n;
		logic [3:0]    hi_n;
		logic [1:0]    btn_n;
		word = 16'hffff;
		pins = stb.joywe_n ? 8'hff : sel;
		for (int k = 0; k < 2; k++) begin
			pad = (k == 0) ? pad0 : pad1;
			if (!ste) begin
				pad = '0;
			end
			lo_n = 4'hf;
			hi_n = 4'hf;
			for (int r = 0; r < 4; r++) begin
				for (int c = 0; c < 4; c++) begin
					if (!pins[4*k+r] && pad.keys[8*r+c]) begin
						lo_n[c] = 1'b0;
					end
					if (!pins[4*k+r] && pad.keys[8*r+4+c]) begin
						hi_n[c] = 1'b0;
					end
				end
			end
			for (int j = 0; j < 2; j++) begin
				btn_n[j] = !(pad.fire[j] && !pins[4*k+j]);
			end
			if (!stb.joyrl_n) word[4*k +: 4] = word[4*k +: 4] & lo_n;
			if (!stb.joyrh_n) word[8+4*k +: 4] = word[8+4*k +: 4] & hi_n;
			if (!stb.button_n) word[2*k +: 2] = word[2*k +: 2] & btn_n;
		end
		return word;
	endfunction

	task automatic check_value(input string name, input cpu_word_t expected,
		input cpu_word_t actual);
		if (expected !== actual) begin
			fail_count = fail_count + 1;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic apply_reset();
		xsint = 1'b0;
		repeat (16) @(posedge clk_32);
		xsint <= 1'b1;
	endtask

	task automatic randomize_pads(input logic ste);
		logic [31:0] r;
		@(posedge clk_32);
		for (int k = 0; k < N_JOY_PORTS; k++) begin
			pad_val[k].keys = rand32();
			r = rand32();
			pad_val[k].fire = r[1:0];
			joy_i[k] <= pad_val[k];
		end
		ste_val = ste;
		ste_mode_i <= ste;
	endtask

	// joywl stays high until the next task drives the strobes
	task automatic write_select(input cpu_byte_t value, input logic we_n);
		@(posedge clk_32);
		strobes_i <= '{joywl: 1'b1, joywe_n: we_n, joyrl_n: 1'b1, joyrh_n: 1'b1, button_n: 1'b1};
		cpu_data_i <= value;
		last_select = value;
	endtask

	// one read cycle with the word taken mid cycle after the registering edge
	task automatic read_word(input joy_strobes_t stb, output cpu_word_t word);
		@(posedge clk_32);
		strobes_i <= stb;
		@(posedge clk_32);
		strobes_i <= '{joywl: 1'b0, joywe_n: stb.joywe_n, joyrl_n: 1'b1, joyrh_n: 1'b1,
			button_n: 1'b1};
		@(negedge clk_32);
		word = rd_data_o;
	endtask

	task automatic test_reset_idle();
		cpu_word_t    word;
		joy_strobes_t stb;
		@(negedge clk_32);
		check_value("reset_idle", 16'hffff, rd_data_o);
		// every key pressed while the select pins stay disabled
		@(posedge clk_32);
		joy_i[0] <= '1;
		joy_i[1] <= '1;
		write_select(8'h00, 1'b1);
		stb = '{joywl: 1'b0, joywe_n: 1'b1, joyrl_n: 1'b0, joyrh_n: 1'b1, button_n: 1'b1};
		read_word(stb, word);
		check_value("reset_pins_off", 16'hffff, word);
	endtask

	task automatic test_random_rows();
		cpu_word_t    word;
		joy_strobes_t stb;
		logic [31:0]  r;
		stb = '{joywl: 1'b0, joywe_n: 1'b0, joyrl_n: 1'b0, joyrh_n: 1'b0, button_n: 1'b1};
		for (int i = 0; i < 40; i++) begin
			randomize_pads(1'b1);
			r = rand32();
			write_select(r[7:0], 1'b0);
			read_word(stb, word);
			check_value("random_rows", model_read(last_select, stb, ste_val, pad_val[0],
				pad_val[1]), word);
		end
	endtask

	task automatic test_fire_buttons();
		cpu_word_t    word;
		joy_strobes_t stb;
		logic [31:0]  r;
		stb = '{joywl: 1'b0, joywe_n: 1'b0, joyrl_n: 1'b1, joyrh_n: 1'b1, button_n: 1'b0};
		for (int i = 0; i < 20; i++) begin
			randomize_pads(1'b1);
			r = rand32();
			write_select(r[7:0], 1'b0);
			read_word(stb, word);
			check_value("fire_buttons", model_read(last_select, stb, ste_val, pad_val[0],
				pad_val[1]), word);
			check_value("fire_upper_bits", 16'hffff, word | 16'h000f);
		end
	endtask

	task automatic test_ste_mode_off();
		cpu_word_t    word;
		joy_strobes_t stb;
		logic [31:0]  r;
		stb = '{joywl: 1'b0, joywe_n: 1'b0, joyrl_n: 1'b0, joyrh_n: 1'b0, button_n: 1'b0};
		for (int i = 0; i < 10; i++) begin
			randomize_pads(1'b0);
			r = rand32();
			write_select(r[7:0], 1'b0);
			read_word(stb, word);
			check_value("ste_mode_off", 16'hffff, word);
		end
	endtask

	task automatic test_write_hold();
		cpu_word_t    word;
		joy_strobes_t stb;
		logic [31:0]  r;
		stb = '{joywl: 1'b0, joywe_n: 1'b0, joyrl_n: 1'b0, joyrh_n: 1'b0, button_n: 1'b1};
		for (int i = 0; i < 5; i++) begin
			randomize_pads(1'b1);
			r = rand32();
			write_select(r[7:0], 1'b0);
			read_word(stb, word);
			check_value("write_hold_first", model_read(last_select, stb, ste_val,
				pad_val[0], pad_val[1]), word);
			// new data on the bus without a write pulse
			@(posedge clk_32);
			cpu_data_i <= ~last_select;
			randomize_pads(1'b1);
			read_word(stb, word);
			check_value("write_hold_kept", model_read(last_select, stb, ste_val,
				pad_val[0], pad_val[1]), word);
		end
	endtask

	initial begin
		xsint = 1'b0;
		strobes_i = '{joywl: 1'b0, joywe_n: 1'b1, joyrl_n: 1'b1, joyrh_n: 1'b1, button_n: 1'b1};
		cpu_data_i = 8'hff;
		ste_mode_i = 1'b1;
		ste_val = 1'b1;
		last_select = 8'hff;
		for (int k = 0; k < N_JOY_PORTS; k++) begin
			joy_i[k] = '0;
			pad_val[k] = '0;
		end
		apply_reset();
		test_reset_idle();
		test_random_rows();
		test_fire_buttons();
		test_ste_mode_off();
		test_write_hold();
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/ste_bus_pkg.sv
verilog/joypad_pkg.sv
verilog/joy_out_latch.sv
verilog/joypad_port.sv
verilog/joy_read_mux.sv
verilog/ste_joy_top.sv
tests/tb_ste_joy.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the joypad port testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_ste_joy --Mdir obj_dir -o Vtb_ste_joy -f list.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_ste_joy > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "result: FAIL"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "result: FAIL, simulator exited with status $status"
	exit 1
fi

echo "result: PASS"
exit 0
